// File: common/mcif_wr_consts.svh
/*
 * Widths and FIFO sizing for the write split stage.
 * FIFO pointers and the count share MCIF_WR_DFIFO_AW bits, so the depth must stay below 8.
 */
`ifndef MCIF_WR_CONSTS_SVH
`define MCIF_WR_CONSTS_SVH

// ==============================
// command fields
// ==============================
`define MCIF_WR_AXID_W 4
`define MCIF_WR_ADDR_W 32
`define MCIF_WR_SIZE_W 3
// low size bits give the sub-command count minus one
`define MCIF_WR_SPLIT_CNT_W 2

// ==============================
// data path
// ==============================
`define MCIF_WR_DAT_W 64
`define MCIF_WR_DAT_PD_W 65
`define MCIF_WR_DFIFO_DEPTH 5
`define MCIF_WR_DFIFO_AW 3
// ready held while count is at or below this
`define MCIF_WR_DFIFO_RDY_MAX 1

`endif

// File: common/mcif_wr_cmd_pkg.sv
/*
 * Write command layout, 45 bits, most significant field first.
 * Bit order matches the upstream arbiter and the downstream converter.
 */
`include "mcif_wr_consts.svh"

package mcif_wr_cmd_pkg;

  // ==============================
  // write command
  // ==============================
  typedef struct packed {
    // first piece of a transfer
    logic                         ftran;
    // last piece of a transfer
    logic                         ltran;
    logic                         inc;
    logic                         odd;
    logic                         swizzle;
    // only the low bits drive the split
    logic [`MCIF_WR_SIZE_W-1:0]   size;
    logic [`MCIF_WR_ADDR_W-1:0]   addr;
    // ack wanted at end of transfer
    logic                         require_ack;
    logic [`MCIF_WR_AXID_W-1:0]   axid;
  } wr_cmd_t;

endpackage

// File: common/mcif_wr_dat_pkg.sv
/*
 * Data beat types. The input word carries one spare bit above the beat.
 */
`include "mcif_wr_consts.svh"

package mcif_wr_dat_pkg;

  typedef logic [`MCIF_WR_DAT_W-1:0] wr_dat_t;

  // spare bit on top, beat below
  typedef struct packed {
    logic [`MCIF_WR_DAT_PD_W-`MCIF_WR_DAT_W-1:0] spare;
    wr_dat_t                                     data;
  } wr_dat_pd_t;

endpackage

// File: dfifo/mcif_wr_spt_flopram.sv
/*
 * Flop RAM, 5 entries. Registered write, combinational read.
 * Addresses above the last entry write nothing and read zero.
 */
`timescale 1ns/1ps
`include "mcif_wr_consts.svh"

module mcif_wr_spt_flopram
  import mcif_wr_dat_pkg::*;
(
  input  logic                         nvdla_core_clk_mgated,
  input  logic                         we,
  input  logic [`MCIF_WR_DFIFO_AW-1:0] wa,
  input  logic [`MCIF_WR_DFIFO_AW-1:0] ra,
  input  wr_dat_t                      di,
  output wr_dat_t                      dout
);

  localparam logic [`MCIF_WR_DFIFO_AW-1:0] DEPTH = `MCIF_WR_DFIFO_AW'(`MCIF_WR_DFIFO_DEPTH);

  wr_dat_t mem [`MCIF_WR_DFIFO_DEPTH];

  // write lands on the edge
  always_ff @(posedge nvdla_core_clk_mgated) begin
    if (we && (wa < DEPTH)) begin
      mem[wa] <= di;
    end
  end

  // read mux
  always_comb begin
    dout = '0;
    if (ra < DEPTH) begin
      dout = mem[ra];
    end
  end

endmodule

// File: dfifo/mcif_wr_spt_dfifo.sv
/*
 * 5-entry data FIFO. Writes on wr_valid alone, wr_ready is advisory.
 * Ready drops above one entry, leaving room for three late beats.
 */
`timescale 1ns/1ps
`include "mcif_wr_consts.svh"

module mcif_wr_spt_dfifo
  import mcif_wr_dat_pkg::*;
(
  input  logic    nvdla_core_clk_mgated,
  input  logic    nvdla_core_rstn,
  input  logic    wr_valid,
  output logic    wr_ready,
  input  wr_dat_t wr_data,
  output logic    rd_valid,
  input  logic    rd_ready,
  output wr_dat_t rd_data
);

  localparam logic [`MCIF_WR_DFIFO_AW-1:0] LAST_ADR = `MCIF_WR_DFIFO_AW'(`MCIF_WR_DFIFO_DEPTH - 1);
  localparam logic [`MCIF_WR_DFIFO_AW-1:0] RDY_MAX  = `MCIF_WR_DFIFO_AW'(`MCIF_WR_DFIFO_RDY_MAX);

  logic [`MCIF_WR_DFIFO_AW-1:0] wr_count;
  logic [`MCIF_WR_DFIFO_AW-1:0] wr_count_nxt;
  logic [`MCIF_WR_DFIFO_AW-1:0] wr_adr;
  logic [`MCIF_WR_DFIFO_AW-1:0] rd_adr;
  logic                         rd_popping;

  // ==============================
  // occupancy
  // ==============================
  assign rd_popping = rd_valid && rd_ready;

  // single clock, push and pop seen by both sides in the same cycle
  always_comb begin
    wr_count_nxt = wr_count;
    if (wr_valid && !rd_popping) begin
      wr_count_nxt = wr_count + 1'b1;
    end else if (!wr_valid && rd_popping) begin
      wr_count_nxt = wr_count - 1'b1;
    end
  end

  assign wr_ready = (wr_count <= RDY_MAX);

  always_ff @(posedge nvdla_core_clk_mgated or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_count <= '0;
      rd_valid <= 1'b0;
    end else begin
      wr_count <= wr_count_nxt;
      // pushed beat is readable one cycle later
      rd_valid <= (wr_count_nxt != '0);
    end
  end

  // ==============================
  // pointers, wrap at depth
  // ==============================
  always_ff @(posedge nvdla_core_clk_mgated or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_adr <= '0;
      rd_adr <= '0;
    end else begin
      if (wr_valid) begin
        wr_adr <= (wr_adr == LAST_ADR) ? '0 : wr_adr + 1'b1;
      end
      if (rd_popping) begin
        rd_adr <= (rd_adr == LAST_ADR) ? '0 : rd_adr + 1'b1;
      end
    end
  end

  mcif_wr_spt_flopram u_ram (
    .nvdla_core_clk_mgated (nvdla_core_clk_mgated),
    .we                    (wr_valid),
    .wa                    (wr_adr),
    .ra                    (rd_adr),
    .di                    (wr_data),
    .dout                  (rd_data)
  );

endmodule

// File: verilog/mcif_wr_spt_cmd_split.sv
/*
 * One-entry command pipe plus splitter into size[1:0]+1 single-size pieces.
 * Holds one command at a time; a new one is taken on the last downstream accept.
 */
`timescale 1ns/1ps
`include "mcif_wr_consts.svh"

module mcif_wr_spt_cmd_split
  import mcif_wr_cmd_pkg::*;
(
  input  logic    nvdla_core_clk_mgated,
  input  logic    nvdla_core_rstn,
  input  logic    in_valid,
  output logic    in_ready,
  input  wr_cmd_t in_cmd,
  output logic    out_valid,
  input  logic    out_ready,
  output wr_cmd_t out_cmd
);

  logic                            pipe_vld;
  wr_cmd_t                         pipe_cmd;
  logic [`MCIF_WR_SPLIT_CNT_W-1:0] tran_cnt;
  logic                            out_accept;
  logic                            is_first;
  logic                            is_last;

  // ==============================
  // pipe register
  // ==============================
  // free when empty or when the last piece leaves this cycle
  assign in_ready = !pipe_vld || (out_ready && is_last);

  always_ff @(posedge nvdla_core_clk_mgated or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pipe_vld <= 1'b0;
    end else if (in_ready) begin
      pipe_vld <= in_valid;
    end
  end

  // payload only
  always_ff @(posedge nvdla_core_clk_mgated) begin
    if (in_valid && in_ready) begin
      pipe_cmd <= in_cmd;
    end
  end

  // ==============================
  // sub-command counter
  // ==============================
  assign out_accept = out_valid && out_ready;
  assign is_first   = (tran_cnt == '0);
  assign is_last    = (tran_cnt == pipe_cmd.size[`MCIF_WR_SPLIT_CNT_W-1:0]);

  always_ff @(posedge nvdla_core_clk_mgated or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      tran_cnt <= '0;
    end else if (out_accept) begin
      if (is_last) begin
        tran_cnt <= '0;
      end else begin
        tran_cnt <= tran_cnt + 1'b1;
      end
    end
  end

  // ==============================
  // outgoing fields
  // ==============================
  assign out_valid = pipe_vld;

  always_comb begin
    // addr, axid, swizzle, odd pass through
    out_cmd             = pipe_cmd;
    // each piece is one atom, never incremented
    out_cmd.size        = '0;
    out_cmd.inc         = 1'b0;
    out_cmd.ftran       = is_first & pipe_cmd.ftran;
    out_cmd.ltran       = is_last & pipe_cmd.ltran;
    // same ack flag on every piece
    out_cmd.require_ack = pipe_cmd.require_ack & pipe_cmd.ltran;
  end

endmodule

// File: verilog/mcif_wr_spt.sv
/*
 * Write ingress split stage. Command and data paths run independently.
 * Upstream data must stop within three cycles of arb2spt_dat_ready falling.
 */
`timescale 1ns/1ps
`include "mcif_wr_consts.svh"

module mcif_wr_spt
  import mcif_wr_cmd_pkg::*, mcif_wr_dat_pkg::*;
(
  input  logic       nvdla_core_clk_mgated,
  input  logic       nvdla_core_rstn,
  // command from arbiter
  input  logic       arb2spt_cmd_valid,
  output logic       arb2spt_cmd_ready,
  input  wr_cmd_t    arb2spt_cmd_pd,
  // data from arbiter, push only
  input  logic       arb2spt_dat_valid,
  output logic       arb2spt_dat_ready,
  input  wr_dat_pd_t arb2spt_dat_pd,
  // split commands to converter
  output logic       spt2cvt_cmd_valid,
  input  logic       spt2cvt_cmd_ready,
  output wr_cmd_t    spt2cvt_cmd_pd,
  // data beats to converter
  output logic       spt2cvt_dat_valid,
  input  logic       spt2cvt_dat_ready,
  output wr_dat_t    spt2cvt_dat_data
);

  // beat without the spare top bit
  wr_dat_t arb_dat_data;

  assign arb_dat_data = arb2spt_dat_pd.data;

  // ==============================
  // command split
  // ==============================
  mcif_wr_spt_cmd_split u_cmd_split (
    .nvdla_core_clk_mgated (nvdla_core_clk_mgated),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .in_valid              (arb2spt_cmd_valid),
    .in_ready              (arb2spt_cmd_ready),
    .in_cmd                (arb2spt_cmd_pd),
    .out_valid             (spt2cvt_cmd_valid),
    .out_ready             (spt2cvt_cmd_ready),
    .out_cmd               (spt2cvt_cmd_pd)
  );

  // ==============================
  // data fifo
  // ==============================
  mcif_wr_spt_dfifo u_dfifo (
    .nvdla_core_clk_mgated (nvdla_core_clk_mgated),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .wr_valid              (arb2spt_dat_valid),
    .wr_ready              (arb2spt_dat_ready),
    .wr_data               (arb_dat_data),
    .rd_valid              (spt2cvt_dat_valid),
    .rd_ready              (spt2cvt_dat_ready),
    .rd_data               (spt2cvt_dat_data)
  );

endmodule

// File: sim/mcif_wr_spt_asserts.sv
/*
 * Bound checker with reference queues for sub-commands and data beats.
 * Each failed assertion bumps fail_cnt, which the testbench reads at the end of a test.
 */
`timescale 1ns/1ps
`include "mcif_wr_consts.svh"

module mcif_wr_spt_asserts
  import mcif_wr_cmd_pkg::*, mcif_wr_dat_pkg::*;
(
  input logic       nvdla_core_clk_mgated,
  input logic       nvdla_core_rstn,
  input logic       arb2spt_cmd_valid,
  input logic       arb2spt_cmd_ready,
  input wr_cmd_t    arb2spt_cmd_pd,
  input logic       arb2spt_dat_valid,
  input logic       arb2spt_dat_ready,
  input wr_dat_pd_t arb2spt_dat_pd,
  input logic       spt2cvt_cmd_valid,
  input logic       spt2cvt_cmd_ready,
  input wr_cmd_t    spt2cvt_cmd_pd,
  input logic       spt2cvt_dat_valid,
  input logic       spt2cvt_dat_ready,
  input wr_dat_t    spt2cvt_dat_data
);

  wr_cmd_t cmd_q[$];
  wr_dat_t dat_q[$];
  wr_cmd_t exp_cmd  = '0;
  wr_dat_t exp_dat  = '0;
  int      cmd_left = 0;
  // pushes minus pops
  int      dat_left = 0;
  int      fail_cnt = 0;

  // ==============================
  // reference model
  // ==============================
  // one input command becomes size[1:0]+1 pieces
  function automatic void expand_cmd(input wr_cmd_t c);
    int      n;
    wr_cmd_t e;
    n = int'(c.size[`MCIF_WR_SPLIT_CNT_W-1:0]) + 1;
    for (int i = 0; i < n; i++) begin
      e             = c;
      e.size        = '0;
      e.inc         = 1'b0;
      e.ftran       = c.ftran && (i == 0);
      e.ltran       = c.ltran && (i == n - 1);
      e.require_ack = c.require_ack && c.ltran;
      cmd_q.push_back(e);
    end
  endfunction

  always @(posedge nvdla_core_clk_mgated or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd_q.delete();
      dat_q.delete();
    end else begin
      // pop before push so the next command lands behind the last piece
      if (spt2cvt_cmd_valid && spt2cvt_cmd_ready && cmd_q.size() != 0) begin
        void'(cmd_q.pop_front());
      end
      if (arb2spt_cmd_valid && arb2spt_cmd_ready) begin
        expand_cmd(arb2spt_cmd_pd);
      end
      if (spt2cvt_dat_valid && spt2cvt_dat_ready && dat_q.size() != 0) begin
        void'(dat_q.pop_front());
      end
      // push on valid alone with the spare bit dropped
      if (arb2spt_dat_valid) begin
        dat_q.push_back(arb2spt_dat_pd.data);
      end
    end
    cmd_left <= cmd_q.size();
    dat_left <= dat_q.size();
    exp_cmd  <= (cmd_q.size() != 0) ? cmd_q[0] : '0;
    exp_dat  <= (dat_q.size() != 0) ? dat_q[0] : '0;
  end

  // ==============================
  // assertions
  // ==============================
  a_reset_idle: assert property (@(posedge nvdla_core_clk_mgated)
    $rose(nvdla_core_rstn) |-> !spt2cvt_cmd_valid && !spt2cvt_dat_valid &&
      arb2spt_cmd_ready && arb2spt_dat_ready)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t valids or readies wrong after reset", $time);
    end

  a_cmd_match: assert property (@(posedge nvdla_core_clk_mgated) disable iff (!nvdla_core_rstn)
    spt2cvt_cmd_valid |-> cmd_left != 0 && spt2cvt_cmd_pd == exp_cmd)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t sub-command %h, expected %h", $time, spt2cvt_cmd_pd, exp_cmd);
    end

  // payload frozen under back-pressure
  a_cmd_hold: assert property (@(posedge nvdla_core_clk_mgated) disable iff (!nvdla_core_rstn)
    spt2cvt_cmd_valid && !spt2cvt_cmd_ready |=> spt2cvt_cmd_valid && $stable(spt2cvt_cmd_pd))
    else begin
      fail_cnt++;
      $error("[FAIL] %0t sub-command changed while stalled", $time);
    end

  // input held off until the last piece is taken
  a_cmd_busy: assert property (@(posedge nvdla_core_clk_mgated) disable iff (!nvdla_core_rstn)
    spt2cvt_cmd_valid && !(cmd_left == 1 && spt2cvt_cmd_ready) |-> !arb2spt_cmd_ready)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t cmd_ready high before the last accept", $time);
    end

  a_dat_match: assert property (@(posedge nvdla_core_clk_mgated) disable iff (!nvdla_core_rstn)
    spt2cvt_dat_valid |-> dat_left != 0 && spt2cvt_dat_data == exp_dat)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t data beat %h, expected %h", $time, spt2cvt_dat_data, exp_dat);
    end

  a_dat_ready: assert property (@(posedge nvdla_core_clk_mgated) disable iff (!nvdla_core_rstn)
    arb2spt_dat_ready == (dat_left <= `MCIF_WR_DFIFO_RDY_MAX))
    else begin
      fail_cnt++;
      $error("[FAIL] %0t dat_ready %0b at occupancy %0d", $time, arb2spt_dat_ready, dat_left);
    end

  a_dat_room: assert property (@(posedge nvdla_core_clk_mgated) disable iff (!nvdla_core_rstn)
    dat_left <= `MCIF_WR_DFIFO_DEPTH)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t occupancy %0d above FIFO depth", $time, dat_left);
    end

endmodule

// File: sim/tb_mcif_wr_spt.sv
/*
 * Testbench for mcif_wr_spt. Values are checked by the bound assertion module.
 * Data is pushed only while arb2spt_dat_ready is high.
 */
`timescale 1ns/1ps

module tb_mcif_wr_spt
  import mcif_wr_cmd_pkg::*, mcif_wr_dat_pkg::*;
();

  localparam int TIMEOUT = 400;

  logic       nvdla_core_clk_mgated;
  logic       nvdla_core_rstn;
  logic       arb2spt_cmd_valid;
  logic       arb2spt_cmd_ready;
  wr_cmd_t    arb2spt_cmd_pd;
  logic       arb2spt_dat_valid;
  logic       arb2spt_dat_ready;
  wr_dat_pd_t arb2spt_dat_pd;
  logic       spt2cvt_cmd_valid;
  logic       spt2cvt_cmd_ready;
  wr_cmd_t    spt2cvt_cmd_pd;
  logic       spt2cvt_dat_valid;
  logic       spt2cvt_dat_ready;
  wr_dat_t    spt2cvt_dat_data;

  // downstream ready, 0 low, 1 high, 2 random
  int cmd_rdy_mode = 1;
  int dat_rdy_mode = 1;
  int tests_run    = 0;
  int tests_failed = 0;
  int timeouts     = 0;
  int err_mark     = 0;

  mcif_wr_spt i_mcif_wr_spt (.*);

  bind mcif_wr_spt mcif_wr_spt_asserts u_asserts (
    .nvdla_core_clk_mgated (nvdla_core_clk_mgated),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .arb2spt_cmd_valid     (arb2spt_cmd_valid),
    .arb2spt_cmd_ready     (arb2spt_cmd_ready),
    .arb2spt_cmd_pd        (arb2spt_cmd_pd),
    .arb2spt_dat_valid     (arb2spt_dat_valid),
    .arb2spt_dat_ready     (arb2spt_dat_ready),
    .arb2spt_dat_pd        (arb2spt_dat_pd),
    .spt2cvt_cmd_valid     (spt2cvt_cmd_valid),
    .spt2cvt_cmd_ready     (spt2cvt_cmd_ready),
    .spt2cvt_cmd_pd        (spt2cvt_cmd_pd),
    .spt2cvt_dat_valid     (spt2cvt_dat_valid),
    .spt2cvt_dat_ready     (spt2cvt_dat_ready),
    .spt2cvt_dat_data      (spt2cvt_dat_data)
  );

  initial begin
    nvdla_core_clk_mgated = 1'b0;
    forever #2 nvdla_core_clk_mgated = ~nvdla_core_clk_mgated;
  end

  // ==============================
  // helpers
  // ==============================
  function automatic logic pick_ready(input int mode);
    if (mode == 2) begin
      return (($urandom % 100) < 60);
    end
    return (mode == 1);
  endfunction

  always @(posedge nvdla_core_clk_mgated) begin
    spt2cvt_cmd_ready <= pick_ready(cmd_rdy_mode);
    spt2cvt_dat_ready <= pick_ready(dat_rdy_mode);
  end

  function automatic wr_cmd_t rand_cmd();
    return wr_cmd_t'(45'({$urandom, $urandom}));
  endfunction

  function automatic wr_dat_pd_t rand_beat();
    return wr_dat_pd_t'(65'({$urandom, $urandom, $urandom}));
  endfunction

  function automatic int total_errors();
    return i_mcif_wr_spt.u_asserts.fail_cnt + timeouts;
  endfunction

  // ready is sampled at the falling edge, stable until the next rise
  task automatic send_cmd(input wr_cmd_t c);
    int waited;
    waited = 0;
    @(posedge nvdla_core_clk_mgated);
    arb2spt_cmd_valid <= 1'b1;
    arb2spt_cmd_pd    <= c;
    @(negedge nvdla_core_clk_mgated);
    while (!arb2spt_cmd_ready && waited < TIMEOUT) begin
      @(negedge nvdla_core_clk_mgated);
      waited++;
    end
    if (waited >= TIMEOUT) begin
      timeouts++;
      $display("timeout at %0t: a command was never accepted", $time);
    end
    @(posedge nvdla_core_clk_mgated);
    arb2spt_cmd_valid <= 1'b0;
  endtask

  // one beat per two cycles, so ready is known before each push
  task automatic send_beat(input wr_dat_pd_t d);
    int waited;
    waited = 0;
    @(negedge nvdla_core_clk_mgated);
    while (!arb2spt_dat_ready && waited < TIMEOUT) begin
      @(negedge nvdla_core_clk_mgated);
      waited++;
    end
    if (waited >= TIMEOUT) begin
      timeouts++;
      $display("timeout at %0t: data ready never came back", $time);
    end else begin
      @(posedge nvdla_core_clk_mgated);
      arb2spt_dat_valid <= 1'b1;
      arb2spt_dat_pd    <= d;
      @(posedge nvdla_core_clk_mgated);
      arb2spt_dat_valid <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge nvdla_core_clk_mgated);
    while ((i_mcif_wr_spt.u_asserts.cmd_left != 0 || i_mcif_wr_spt.u_asserts.dat_left != 0 ||
            spt2cvt_cmd_valid || spt2cvt_dat_valid) && waited < TIMEOUT) begin
      @(negedge nvdla_core_clk_mgated);
      waited++;
    end
    if (waited >= TIMEOUT) begin
      timeouts++;
      $display("timeout at %0t: expected commands or beats never came out", $time);
    end
  endtask

  task automatic finish_test(input string name);
    int new_errs;
    new_errs = total_errors() - err_mark;
    tests_run++;
    if (new_errs == 0) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("[FAIL] %0t test %s: %0d checks failed", $time, name, new_errs);
    end
    err_mark = total_errors();
  endtask

  // ==============================
  // test sequence
  // ==============================
  initial begin
    wr_cmd_t c;
    void'($urandom(2846));
    nvdla_core_rstn   = 1'b0;
    arb2spt_cmd_valid = 1'b0;
    arb2spt_cmd_pd    = '0;
    arb2spt_dat_valid = 1'b0;
    arb2spt_dat_pd    = '0;
    spt2cvt_cmd_ready = 1'b1;
    spt2cvt_dat_ready = 1'b1;
    repeat (5) @(posedge nvdla_core_clk_mgated);
    nvdla_core_rstn <= 1'b1;
    repeat (3) @(posedge nvdla_core_clk_mgated);
    finish_test("reset_state");

    // every size with every ftran/ltran pair
    for (int s = 0; s < 8; s++) begin
      for (int f = 0; f < 4; f++) begin
        c             = rand_cmd();
        c.size        = 3'(s);
        c.ftran       = f[0];
        c.ltran       = f[1];
        c.require_ack = 1'b1;
        send_cmd(c);
      end
    end
    wait_drain();
    finish_test("split_sizes_flags");

    cmd_rdy_mode = 2;
    repeat (40) send_cmd(rand_cmd());
    wait_drain();
    finish_test("cmd_backpressure");

    dat_rdy_mode = 2;
    repeat (60) send_beat(rand_beat());
    wait_drain();
    finish_test("data_order");

    // stall downstream until ready drops at two beats
    dat_rdy_mode = 0;
    repeat (2) send_beat(rand_beat());
    repeat (6) @(posedge nvdla_core_clk_mgated);
    dat_rdy_mode = 1;
    wait_drain();
    finish_test("data_ready_threshold");

    dat_rdy_mode = 2;
    fork
      repeat (20) send_cmd(rand_cmd());
      repeat (30) send_beat(rand_beat());
    join
    wait_drain();
    finish_test("mixed_traffic");

    $display("tests run %0d, failed %0d, assertion failures %0d, timeouts %0d",
             tests_run, tests_failed, i_mcif_wr_spt.u_asserts.fail_cnt, timeouts);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+common
common/mcif_wr_cmd_pkg.sv
common/mcif_wr_dat_pkg.sv
dfifo/mcif_wr_spt_flopram.sv
dfifo/mcif_wr_spt_dfifo.sv
verilog/mcif_wr_spt_cmd_split.sv
verilog/mcif_wr_spt.sv
sim/mcif_wr_spt_asserts.sv
sim/tb_mcif_wr_spt.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_mcif_wr_spt -o sim_tb \
  && ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log && exit 0 || exit 1
